// File: source/sdram_consts.svh
// ************************************************************************
// Geometry, init slot and access phase constants of the SDRAM controller
// Included by the package and by any file that needs the raw numbers
// ************************************************************************
`ifndef SDRAM_CONSTS_SVH
`define SDRAM_CONSTS_SVH

// SDRAM geometry of 4 banks x 2048 rows x 256 columns of 32 bits
`define SDRAM_COL_W         8
`define SDRAM_ROW_W         11
`define SDRAM_BA_W          2
`define SDRAM_A_W           11
`define SDRAM_DQ_W          32
`define SDRAM_DQM_W         4
`define SDRAM_AP_BIT        10
`define HOST_ADDR_W         23

// Init counter slots
`define INIT_REF1_SLOT      8
`define INIT_REF2_SLOT      16
`define INIT_SMR_SLOT       24
`define INIT_DONE_SLOT      32

// Mode register fields
`define MR_CAS_LATENCY      3'd2
`define MR_BURST_LENGTH     3'b000
`define MR_BURST_TYPE       1'b0
`define MR_WRITE_BURST      1'b0

// Access phases counted from the idle cycle
`define PH_DRIVE_WDATA      1
`define PH_RW_CMD           3
`define PH_RELEASE_DQ       5
`define PH_CAPTURE          6
`define PH_ACK_LAST         7
`define ACCESS_LAST_PHASE   8

`endif

// File: source/sdram_pkg.sv
// ************************************************************************
// Shared types of the SDRAM controller: host request, address views,
// SDRAM command coding and the pin-level bus bundles
// ************************************************************************
`include "sdram_consts.svh"

package sdram_pkg;

    typedef enum logic [1:0] {
        size_8  = 2'd0,
        size_16 = 2'd1,
        size_32 = 2'd2
    } access_size_e;

    // Encoded as {CS_n, RAS_n, CAS_n, WE_n}
    typedef enum logic [3:0] {
        cmd_dis = 4'b1111,
        cmd_smr = 4'b0000,
        cmd_ref = 4'b0001,
        cmd_pre = 4'b0010,
        cmd_act = 4'b0011,
        cmd_wr  = 4'b0100,
        cmd_rd  = 4'b0101,
        cmd_nop = 4'b0111
    } sdram_cmd_e;

    typedef struct packed {
        logic [`SDRAM_BA_W-1:0]  bank;
        logic [`SDRAM_ROW_W-1:0] row;
        logic [`SDRAM_COL_W-1:0] col;
        logic [1:0]              ofs;
    } addr_fields_t;

    // Flat byte address, or the same bits split into SDRAM coordinates
    typedef union packed {
        logic [`HOST_ADDR_W-1:0] byte_addr;
        addr_fields_t            fields;
    } host_addr_u;

    typedef struct packed {
        logic                   rd;
        logic                   wr;
        logic                   rfsh;
        host_addr_u             addr;
        logic [`SDRAM_DQ_W-1:0] din;
        access_size_e           size;
    } host_req_t;

    typedef struct packed {
        sdram_cmd_e             cmd;
        logic [`SDRAM_BA_W-1:0] ba;
        logic [`SDRAM_A_W-1:0]  a;
    } sdram_bus_t;

    typedef struct packed {
        logic [`SDRAM_DQ_W-1:0]  dq;
        logic [`SDRAM_DQM_W-1:0] dqm;
        logic                    oe;
    } wr_lane_t;

endpackage

// File: source/sdram_sequencer.sv
// ************************************************************************
// Phase counter of the SDRAM controller. Runs the power-up sequence, then
// accepts one request per idle cycle and steps through its command slots
// ************************************************************************
`timescale 1ns/100ps
`include "sdram_consts.svh"

module sdram_sequencer
(
    input  logic                      CLK,
    input  logic                      RESET_n,
    input  sdram_pkg::host_req_t      req,
    output logic                      ready,
    output logic                      ack,
    output sdram_pkg::sdram_bus_t     next_bus,
    output sdram_pkg::host_addr_u     saved_addr,
    output sdram_pkg::access_size_e   saved_size,
    output logic                      drive_wdata,
    output logic                      release_dq,
    output logic                      assert_dqm,
    output logic                      capture_rdata
);

    localparam logic [6:0] st_init_pre  = 7'd0;
    localparam logic [6:0] st_init_ref1 = 7'(`INIT_REF1_SLOT);
    localparam logic [6:0] st_init_ref2 = 7'(`INIT_REF2_SLOT);
    localparam logic [6:0] st_init_smr  = 7'(`INIT_SMR_SLOT);
    localparam logic [6:0] st_idle      = 7'(`INIT_DONE_SLOT);
    localparam logic [6:0] st_wdata     = 7'(`INIT_DONE_SLOT + `PH_DRIVE_WDATA);
    localparam logic [6:0] st_rw        = 7'(`INIT_DONE_SLOT + `PH_RW_CMD);
    localparam logic [6:0] st_release   = 7'(`INIT_DONE_SLOT + `PH_RELEASE_DQ);
    localparam logic [6:0] st_capture   = 7'(`INIT_DONE_SLOT + `PH_CAPTURE);
    localparam logic [6:0] st_ack_last  = 7'(`INIT_DONE_SLOT + `PH_ACK_LAST);
    localparam logic [6:0] st_last      = 7'(`INIT_DONE_SLOT + `ACCESS_LAST_PHASE);

    logic [6:0] state;
    logic       start;
    logic       saved_rd;
    logic       saved_wr;

    assign start = (state == st_idle) && (req.rd || req.wr || req.rfsh);

    // Init slots count straight up into idle; accesses loop back to idle
    always_ff @(posedge CLK or negedge RESET_n)
    begin
        if (!RESET_n)
        begin
            state    <= st_init_pre;
            ready    <= 1'b0;
            ack      <= 1'b0;
            saved_rd <= 1'b0;
            saved_wr <= 1'b0;
        end
        else
        begin
            if (state == st_idle)
            begin
                ready <= 1'b1;
                if (start)
                    state <= state + 7'd1;
            end
            else if (state == st_last)
                state <= st_idle;
            else
                state <= state + 7'd1;

            if (start)
            begin
                ack      <= 1'b1;
                saved_rd <= req.rd;
                saved_wr <= req.wr;
            end
            else if (state == st_ack_last)
                ack <= 1'b0;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (start)
        begin
            saved_addr <= req.addr;
            saved_size <= req.size;
        end
    end

    assign drive_wdata   = (state == st_wdata) && saved_wr;
    assign assert_dqm    = (state == st_rw) && saved_wr;
    assign release_dq    = (state == st_release);
    assign capture_rdata = (state == st_capture) && saved_rd;

    // Command for the pins in the following cycle
    always_comb
    begin
        next_bus.cmd = sdram_pkg::cmd_nop;
        next_bus.ba  = '0;
        next_bus.a   = '0;
        case (state)
            st_init_pre:
            begin
                // Precharge all banks
                next_bus.cmd               = sdram_pkg::cmd_pre;
                next_bus.a[`SDRAM_AP_BIT] = 1'b1;
            end
            st_init_ref1, st_init_ref2:
                next_bus.cmd = sdram_pkg::cmd_ref;
            st_init_smr:
            begin
                next_bus.cmd = sdram_pkg::cmd_smr;
                next_bus.a   = {1'b0, `MR_WRITE_BURST, 2'b00, `MR_CAS_LATENCY,
                                `MR_BURST_TYPE, `MR_BURST_LENGTH};
            end
            st_idle:
            begin
                if (req.rd || req.wr)
                begin
                    next_bus.cmd = sdram_pkg::cmd_act;
                    next_bus.ba  = req.addr.fields.bank;
                    next_bus.a   = req.addr.fields.row;
                end
                else if (req.rfsh)
                    next_bus.cmd = sdram_pkg::cmd_ref;
            end
            st_rw:
            begin
                if (saved_rd || saved_wr)
                begin
                    next_bus.cmd = saved_wr ? sdram_pkg::cmd_wr : sdram_pkg::cmd_rd;
                    next_bus.ba  = saved_addr.fields.bank;
                    next_bus.a   = `SDRAM_A_W'(saved_addr.fields.col);
                    // Auto-precharge closes the row after the access
                    next_bus.a[`SDRAM_AP_BIT] = 1'b1;
                end
            end
            default:
                next_bus.cmd = sdram_pkg::cmd_nop;
        endcase
    end

endmodule

// File: source/sdram_lane_map.sv
// ************************************************************************
// Byte-lane steering for the 32-bit DQ bus: replicates write data, forms
// the write DQM and right-aligns read data by the byte offset
// ************************************************************************
`timescale 1ns/100ps
`include "sdram_consts.svh"

module sdram_lane_map
(
    input  logic                      CLK,
    input  logic                      RESET_n,
    input  logic [`SDRAM_DQ_W-1:0]    din,
    input  sdram_pkg::host_addr_u     saved_addr,
    input  sdram_pkg::access_size_e   saved_size,
    input  logic                      drive_wdata,
    input  logic                      release_dq,
    input  logic                      assert_dqm,
    input  logic [`SDRAM_DQ_W-1:0]    dq_in,
    output sdram_pkg::wr_lane_t       next_lane,
    output logic [`SDRAM_DQ_W-1:0]    rdata_aligned
);

    logic [`SDRAM_DQ_W-1:0]  din_q;
    logic [`SDRAM_DQ_W-1:0]  wdata;
    logic [`SDRAM_DQM_W-1:0] lane_dqm;
    logic                    oe_hold;
    logic [1:0]              ofs;

    assign ofs = saved_addr.fields.ofs;

    // Output enable stays on from drive_wdata until release_dq
    always_ff @(posedge CLK or negedge RESET_n)
    begin
        if (!RESET_n)
            oe_hold <= 1'b0;
        else if (release_dq)
            oe_hold <= 1'b0;
        else if (drive_wdata)
            oe_hold <= 1'b1;
    end

    // Host data is sampled while the bus is free, frozen during a write
    always_ff @(posedge CLK)
    begin
        if (!drive_wdata && !oe_hold)
            din_q <= din;
    end

    always_comb
    begin
        case (saved_size)
            sdram_pkg::size_8:
            begin
                wdata    = {4{din_q[7:0]}};
                lane_dqm = ~(4'b0001 << ofs);
            end
            sdram_pkg::size_16:
            begin
                wdata    = {2{din_q[15:0]}};
                lane_dqm = ofs[1] ? 4'b0011 : 4'b1100;
            end
            default:
            begin
                wdata    = din_q;
                lane_dqm = 4'b0000;
            end
        endcase
    end

    assign next_lane.dq  = wdata;
    assign next_lane.dqm = assert_dqm ? lane_dqm : {`SDRAM_DQM_W{1'b1}};
    assign next_lane.oe  = drive_wdata || (oe_hold && !release_dq);

    // Zero fill from the top
    assign rdata_aligned = dq_in >> {ofs, 3'b000};

endmodule

// File: source/sdram_pin_stage.sv
// ************************************************************************
// Output register stage. Command, address, DQM and write lanes reach the
// SDRAM pins together, and read data is held here for the host
// ************************************************************************
`timescale 1ns/100ps
`include "sdram_consts.svh"

module sdram_pin_stage
(
    input  logic                       CLK,
    input  logic                       RESET_n,
    input  sdram_pkg::sdram_bus_t      next_bus,
    input  sdram_pkg::wr_lane_t        next_lane,
    input  logic                       capture_rdata,
    input  logic [`SDRAM_DQ_W-1:0]     rdata_aligned,
    output sdram_pkg::sdram_bus_t      bus,
    output logic [`SDRAM_DQM_W-1:0]    dqm,
    output logic [`SDRAM_DQ_W-1:0]     dq_out,
    output logic                       dq_oe,
    output logic [`SDRAM_DQ_W-1:0]     dout
);

    always_ff @(posedge CLK or negedge RESET_n)
    begin
        if (!RESET_n)
        begin
            bus.cmd <= sdram_pkg::cmd_nop;
            bus.ba  <= '0;
            bus.a   <= '0;
            dqm     <= {`SDRAM_DQM_W{1'b1}};
            dq_oe   <= 1'b0;
        end
        else
        begin
            bus   <= next_bus;
            dqm   <= next_lane.dqm;
            dq_oe <= next_lane.oe;
        end
    end

    always_ff @(posedge CLK)
    begin
        dq_out <= next_lane.dq;
        // Last read word stays until the next read
        if (capture_rdata)
            dout <= rdata_aligned;
    end

endmodule

// File: source/sdram_ctrl.sv
// ************************************************************************
// SDRAM controller top. Sequencer and lane map run side by side and the
// pin stage registers both onto the split DQ bus
// ************************************************************************
`timescale 1ns/100ps
`include "sdram_consts.svh"

module sdram_ctrl
(
    input  logic                       CLK,
    input  logic                       RESET_n,
    input  sdram_pkg::host_req_t       req,
    output logic                       ready,
    output logic                       ack,
    output logic [`SDRAM_DQ_W-1:0]     dout,
    output sdram_pkg::sdram_bus_t      bus,
    output logic [`SDRAM_DQM_W-1:0]    dqm,
    output logic [`SDRAM_DQ_W-1:0]     dq_out,
    output logic                       dq_oe,
    input  logic [`SDRAM_DQ_W-1:0]     dq_in
);

    sdram_pkg::sdram_bus_t    next_bus;
    sdram_pkg::wr_lane_t      next_lane;
    sdram_pkg::host_addr_u    saved_addr;
    sdram_pkg::access_size_e  saved_size;
    logic                     drive_wdata;
    logic                     release_dq;
    logic                     assert_dqm;
    logic                     capture_rdata;
    logic [`SDRAM_DQ_W-1:0]   rdata_aligned;

    sdram_sequencer u_sequencer
    (
        .CLK           (CLK),
        .RESET_n       (RESET_n),
        .req           (req),
        .ready         (ready),
        .ack           (ack),
        .next_bus      (next_bus),
        .saved_addr    (saved_addr),
        .saved_size    (saved_size),
        .drive_wdata   (drive_wdata),
        .release_dq    (release_dq),
        .assert_dqm    (assert_dqm),
        .capture_rdata (capture_rdata)
    );

    sdram_lane_map u_lane_map
    (
        .CLK           (CLK),
        .RESET_n       (RESET_n),
        .din           (req.din),
        .saved_addr    (saved_addr),
        .saved_size    (saved_size),
        .drive_wdata   (drive_wdata),
        .release_dq    (release_dq),
        .assert_dqm    (assert_dqm),
        .dq_in         (dq_in),
        .next_lane     (next_lane),
        .rdata_aligned (rdata_aligned)
    );

    sdram_pin_stage u_pin_stage
    (
        .CLK           (CLK),
        .RESET_n       (RESET_n),
        .next_bus      (next_bus),
        .next_lane     (next_lane),
        .capture_rdata (capture_rdata),
        .rdata_aligned (rdata_aligned),
        .bus           (bus),
        .dqm           (dqm),
        .dq_out        (dq_out),
        .dq_oe         (dq_oe),
        .dout          (dout)
    );

endmodule

// File: dv/sdram_model.sv
// ************************************************************************
// Behavioral 32-bit SDRAM for the controller testbench. Decodes commands
// on CLK, stores words sparsely, honours DQM and CAS latency 2
// ************************************************************************
`timescale 1ns/100ps
`include "sdram_consts.svh"

module sdram_model
(
    input  logic                      CLK,
    input  logic                      RESET_n,
    input  sdram_pkg::sdram_bus_t     bus,
    input  logic [`SDRAM_DQM_W-1:0]   dqm,
    input  logic [`SDRAM_DQ_W-1:0]    dq,
    output logic [`SDRAM_DQ_W-1:0]    rd_data,
    output logic                      rd_oe,
    output logic                      fault
);

    logic [`SDRAM_DQ_W-1:0]  mem [logic [20:0]];
    logic [`SDRAM_ROW_W-1:0] open_row [4];
    logic [3:0]              row_open;
    logic [20:0]             rd_cell;
    logic                    rd_pend;
    logic                    mode_set;
    string                   fault_msg;

    // Unwritten cells read back a pattern built from the cell address
    function automatic logic [31:0] cell_word(input logic [20:0] key);
        if (mem.exists(key))
            return mem[key];
        return {key, 11'h4B3};
    endfunction

    function automatic logic [31:0] merge_lanes(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0] mask);
        logic [31:0] word;
        word = old;
        for (int i = 0; i < 4; i++)
            if (!mask[i])
                word[8*i +: 8] = data[8*i +: 8];
        return word;
    endfunction

    // Keeps the first fault only
    task automatic report(input string msg);
        if (!fault)
        begin
            fault     = 1'b1;
            fault_msg = msg;
        end
    endtask

    initial
    begin
        fault    = 1'b0;
        mode_set = 1'b0;
        row_open = 4'b0000;
        rd_pend  = 1'b0;
        rd_oe    = 1'b0;
        rd_data  = '0;
    end

    always @(posedge CLK)
    begin
        logic [20:0] key;
        key = {bus.ba, open_row[bus.ba], bus.a[`SDRAM_COL_W-1:0]};
        // Data of a read sampled at the previous edge is driven for one cycle
        rd_oe   <= rd_pend;
        rd_data <= rd_pend ? cell_word(rd_cell) : '0;
        rd_pend = 1'b0;
        if (RESET_n)
        begin
            if (!mode_set && bus.cmd inside {sdram_pkg::cmd_act, sdram_pkg::cmd_rd,
                                             sdram_pkg::cmd_wr})
                report("access command before the mode register was set");
            case (bus.cmd)
                sdram_pkg::cmd_act:
                begin
                    if (row_open[bus.ba])
                        report("ACT to a bank whose row is still open");
                    row_open[bus.ba] = 1'b1;
                    open_row[bus.ba] = bus.a;
                end
                sdram_pkg::cmd_wr, sdram_pkg::cmd_rd:
                begin
                    if (!row_open[bus.ba])
                        report("RD or WR to a bank with no open row");
                    if (bus.cmd == sdram_pkg::cmd_wr)
                        mem[key] = merge_lanes(cell_word(key), dq, dqm);
                    else
                    begin
                        rd_pend = 1'b1;
                        rd_cell = key;
                    end
                    if (bus.a[`SDRAM_AP_BIT])
                        row_open[bus.ba] = 1'b0;
                end
                sdram_pkg::cmd_pre:
                begin
                    if (bus.a[`SDRAM_AP_BIT])
                        row_open = 4'b0000;
                    else
                        row_open[bus.ba] = 1'b0;
                end
                sdram_pkg::cmd_ref:
                begin
                    if (row_open != 4'b0000)
                        report("REF while a row is open");
                end
                sdram_pkg::cmd_smr:
                begin
                    if (row_open != 4'b0000)
                        report("mode register set while a row is open");
                    // CL2, sequential, burst length 1
                    if (bus.a[6:4] != 3'd2 || bus.a[3:0] != 4'b0000)
                        report("unsupported mode register value");
                    mode_set = 1'b1;
                end
                sdram_pkg::cmd_nop, sdram_pkg::cmd_dis:
                    ;
                default:
                    report("undefined SDRAM command");
            endcase
        end
    end

endmodule

// File: dv/sdram_properties.sv
// ************************************************************************
// Concurrent protocol checks, bound into every instance of the controller
// ************************************************************************
`timescale 1ns/100ps

module sdram_properties
(
    input logic                  CLK,
    input logic                  RESET_n,
    input logic                  ready,
    input logic                  ack,
    input logic                  dq_oe,
    input sdram_pkg::sdram_bus_t bus
);

    int fail_count = 0;

    // Controller must not drive DQ while a read is issued
    assert property (@(posedge CLK) disable iff (!RESET_n)
        bus.cmd == sdram_pkg::cmd_rd |-> !dq_oe)
        else begin fail_count++; $error("dq_oe high in a cycle with RD"); end

    assert property (@(posedge CLK) disable iff (!RESET_n) !ready |-> !ack)
        else begin fail_count++; $error("ack high before ready"); end

    // After init only access and refresh traffic
    assert property (@(posedge CLK) disable iff (!RESET_n)
        ready |-> bus.cmd inside {sdram_pkg::cmd_act, sdram_pkg::cmd_rd,
                                  sdram_pkg::cmd_wr, sdram_pkg::cmd_ref,
                                  sdram_pkg::cmd_nop})
        else begin fail_count++; $error("unexpected command after ready"); end

endmodule

bind sdram_ctrl sdram_properties u_props
(
    .CLK     (CLK),
    .RESET_n (RESET_n),
    .ready   (ready),
    .ack     (ack),
    .dq_oe   (dq_oe),
    .bus     (bus)
);

// File: dv/tb_sdram_ctrl.sv
// ************************************************************************
// Testbench for the SDRAM controller. Runs init, mixed-size writes, narrow
// reads, refresh, address decode and ack timing against a shadow memory
// ************************************************************************
`timescale 1ns/100ps
`include "sdram_consts.svh"

module tb_sdram_ctrl;

    localparam int N_CELLS    = 8;
    localparam int N_MIX      = 24;
    localparam int N_ACCESSES = N_CELLS + 2 * N_MIX + 9 + (1 + N_CELLS) + 8 + 2;

    typedef enum {op_read, op_write, op_refresh} op_e;

    typedef struct packed {
        logic        is_rd;
        logic [31:0] word;
    } pending_t;

    logic                    CLK;
    logic                    RESET_n;
    sdram_pkg::host_req_t    req;
    logic                    ready;
    logic                    ack;
    logic [31:0]             dout;
    sdram_pkg::sdram_bus_t   bus;
    logic [3:0]              dqm;
    logic [31:0]             dq_out;
    logic                    dq_oe;
    logic [31:0]             dq_in;
    logic [31:0]             model_dq;
    logic                    model_oe;
    logic                    model_fault;
    int                      ref_cnt;
    int                      cycle_cnt;
    sdram_pkg::sdram_bus_t   init_cmds[$];
    sdram_pkg::sdram_bus_t   last_act;
    sdram_pkg::sdram_bus_t   last_rw;
    logic [31:0]             shadow [logic [20:0]];
    pending_t                pending_q[$];

    // Resolved DQ bus
    assign dq_in = dq_oe ? dq_out : (model_oe ? model_dq : '0);

    sdram_ctrl dut
    (
        .CLK     (CLK),
        .RESET_n (RESET_n),
        .req     (req),
        .ready   (ready),
        .ack     (ack),
        .dout    (dout),
        .bus     (bus),
        .dqm     (dqm),
        .dq_out  (dq_out),
        .dq_oe   (dq_oe),
        .dq_in   (dq_in)
    );

    sdram_model u_model
    (
        .CLK     (CLK),
        .RESET_n (RESET_n),
        .bus     (bus),
        .dqm     (dqm),
        .dq      (dq_in),
        .rd_data (model_dq),
        .rd_oe   (model_oe),
        .fault   (model_fault)
    );

    initial
    begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        if (got !== exp)
            fail_run($sformatf("[FAIL] %0.1f ns: %s got %h, expected %h",
                               $realtime, what, got, exp));
    endtask

    task automatic check_cmd(input sdram_pkg::sdram_cmd_e got,
                             input sdram_pkg::sdram_cmd_e exp, input string what);
        if (got !== exp)
            fail_run($sformatf("[FAIL] %0.1f ns: %s got %s, expected %s",
                               $realtime, what, got.name(), exp.name()));
    endtask

    // Lane merge of a host write into the stored word
    function automatic logic [31:0] merge_write(input logic [31:0] old,
                                                input logic [31:0] din,
                                                input sdram_pkg::access_size_e size,
                                                input logic [1:0] ofs);
        logic [31:0] word;
        word = old;
        case (size)
            sdram_pkg::size_8:  word[8*ofs +: 8] = din[7:0];
            sdram_pkg::size_16: word[16*ofs[1] +: 16] = din[15:0];
            default:            word = din;
        endcase
        return word;
    endfunction

    // Stored word shifted right by the byte offset with zero fill
    function automatic logic [31:0] expected_dout(input sdram_pkg::host_addr_u addr);
        return shadow[addr.byte_addr[22:2]] >> (8 * addr.fields.ofs);
    endfunction

    // Returns the number of edges until ack reaches the level
    task automatic wait_ack(input logic level, output int n);
        n = 0;
        while (ack !== level)
        begin
            @(posedge CLK);
            #0.5;
            n++;
            if (n > 20)
                fail_run($sformatf("ack did not reach %0b within 20 cycles", level));
        end
    endtask

    task automatic run_access(input op_e op, input sdram_pkg::host_addr_u addr,
                              input sdram_pkg::access_size_e size, input logic [31:0] din);
        pending_t    rec;
        logic [20:0] key;
        int          n;
        key = addr.byte_addr[22:2];
        if (op == op_read && !shadow.exists(key))
            fail_run("testbench reads a cell it never wrote");
        rec.is_rd = (op == op_read);
        rec.word  = (op == op_read) ? expected_dout(addr) : '0;
        pending_q.push_back(rec);
        last_act.cmd = sdram_pkg::cmd_nop;
        last_rw.cmd  = sdram_pkg::cmd_nop;
        req.rd   = (op == op_read);
        req.wr   = (op == op_write);
        req.rfsh = (op == op_refresh);
        req.addr = addr;
        req.size = size;
        req.din  = din;
        wait_ack(1'b1, n);
        req.rd   = 1'b0;
        req.wr   = 1'b0;
        req.rfsh = 1'b0;
        if (op == op_write)
            shadow[key] = merge_write(shadow.exists(key) ? shadow[key] : '0, din, size,
                                      addr.fields.ofs);
        wait_ack(1'b0, n);
        check_word(32'(n), 32'd7, "ack high cycles");
        if (op != op_refresh)
        begin
            check_cmd(last_act.cmd, sdram_pkg::cmd_act, "ACT command");
            check_word(32'(last_act.ba), 32'(addr.fields.bank), "ACT bank");
            check_word(32'(last_act.a), 32'(addr.fields.row), "ACT row");
            check_cmd(last_rw.cmd, (op == op_write) ? sdram_pkg::cmd_wr : sdram_pkg::cmd_rd,
                      "RD/WR command");
            check_word(32'(last_rw.ba), 32'(addr.fields.bank), "RD/WR bank");
            check_word(32'(last_rw.a), 32'(addr.fields.col) | 32'h400, "RD/WR column and A10");
        end
    endtask

    // Bus monitor that samples the pins like the SDRAM does
    always @(posedge CLK)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (RESET_n)
        begin
            if (!ready && bus.cmd != sdram_pkg::cmd_nop)
                init_cmds.push_back(bus);
            if (ready && bus.cmd == sdram_pkg::cmd_ref)
                ref_cnt = ref_cnt + 1;
            if (bus.cmd == sdram_pkg::cmd_act)
                last_act = bus;
            if (bus.cmd == sdram_pkg::cmd_rd || bus.cmd == sdram_pkg::cmd_wr)
                last_rw = bus;
            // Only the WR cycle opens byte lanes
            if (bus.cmd != sdram_pkg::cmd_wr)
                check_word(32'(dqm), 32'hF, "DQM outside a write command");
            if (dq_oe && model_oe)
                fail_run("DQ bus driven by the controller and the SDRAM model at once");
        end
    end

    // Compare process with one record per acked request
    initial
    begin
        pending_t rec;
        wait (RESET_n === 1'b1);
        forever
        begin
            @(negedge ack);
            if (pending_q.size() == 0)
                fail_run("ack from the controller with no request pending");
            else
            begin
                rec = pending_q.pop_front();
                if (rec.is_rd)
                    check_word(dout, rec.word, "dout");
            end
        end
    end

    initial
    begin
        wait (model_fault === 1'b1);
        fail_run($sformatf("SDRAM model protocol error: %s", u_model.fault_msg));
    end

    initial
    begin
        wait (dut.u_props.fail_count != 0);
        fail_run("a protocol assertion on the controller failed");
    end

    initial
    begin
        repeat (N_ACCESSES * 12 + 100) @(posedge CLK);
        fail_run("timeout, the tests did not finish in time");
    end

    initial
    begin
        sdram_pkg::host_addr_u cells [N_CELLS];
        sdram_pkg::host_addr_u dec [4];
        sdram_pkg::host_addr_u a;
        int                    n;
        int                    r0;
        int                    t1;
        int                    t2;
        pending_t              rec;
        void'($urandom(1));
        RESET_n   = 1'b0;
        req       = '0;
        ref_cnt   = 0;
        cycle_cnt = 0;
        last_act  = '0;
        last_rw   = '0;
        repeat (4) @(posedge CLK);
        #0.5;
        RESET_n = 1'b1;

        // Init sequence
        n = 0;
        while (!ready)
        begin
            @(posedge CLK);
            #0.5;
            n++;
            if (n > 60)
                fail_run("ready never rose after reset");
        end
        check_word(32'(n), 32'd33, "cycles from reset release to ready");
        check_word(32'(init_cmds.size()), 32'd4, "init command count");
        check_cmd(init_cmds[0].cmd, sdram_pkg::cmd_pre, "init command 0");
        check_word(32'(init_cmds[0].a[10]), 32'd1, "precharge-all A10");
        check_cmd(init_cmds[1].cmd, sdram_pkg::cmd_ref, "init command 1");
        check_cmd(init_cmds[2].cmd, sdram_pkg::cmd_ref, "init command 2");
        check_cmd(init_cmds[3].cmd, sdram_pkg::cmd_smr, "init command 3");
        // CL2 in A6..A4, sequential, burst length 1
        check_word(32'(init_cmds[3].a), 32'd2 << 4, "mode register value");

        // Mixed writes, each read back as a word
        for (int i = 0; i < N_CELLS; i++)
        begin
            cells[i] = '0;
            cells[i].fields.bank = 2'(i);
            cells[i].fields.row  = {i[2], 10'($urandom)};
            cells[i].fields.col  = 8'($urandom);
            run_access(op_write, cells[i], sdram_pkg::size_32, $urandom);
        end
        for (int j = 0; j < N_MIX; j++)
        begin
            a = cells[$urandom % N_CELLS];
            a.fields.ofs = 2'($urandom);
            run_access(op_write, a, sdram_pkg::access_size_e'(2'($urandom % 3)), $urandom);
            a.fields.ofs = 2'd0;
            run_access(op_read, a, sdram_pkg::size_32, '0);
        end

        // Narrow reads at every offset
        a = cells[2];
        run_access(op_write, a, sdram_pkg::size_32, 32'h8E17_D26B);
        for (int k = 0; k < 4; k++)
        begin
            a.fields.ofs = 2'(k);
            run_access(op_read, a, sdram_pkg::size_8, '0);
            run_access(op_read, a, sdram_pkg::size_16, '0);
        end

        // Refresh keeps the stored data
        r0 = ref_cnt;
        run_access(op_refresh, cells[0], sdram_pkg::size_32, '0);
        check_word(32'(ref_cnt - r0), 32'd1, "REF commands for one refresh");
        for (int i = 0; i < N_CELLS; i++)
            run_access(op_read, cells[i], sdram_pkg::size_32, '0);

        // Bank, row and column land in separate cells
        dec[0] = '0;
        dec[0].fields.bank = 2'd1;
        dec[0].fields.row  = 11'h155;
        dec[0].fields.col  = 8'h3C;
        dec[1] = dec[0];
        dec[1].fields.bank = 2'd2;
        dec[2] = dec[0];
        dec[2].fields.row  = 11'h2AA;
        dec[3] = dec[0];
        dec[3].fields.col  = 8'hC3;
        for (int k = 0; k < 4; k++)
            run_access(op_write, dec[k], sdram_pkg::size_32, 32'h1111_1111 * 32'(k + 1));
        for (int k = 0; k < 4; k++)
            run_access(op_read, dec[k], sdram_pkg::size_32, '0);

        // Read level held through two accesses
        rec.is_rd = 1'b1;
        rec.word  = expected_dout(cells[1]);
        pending_q.push_back(rec);
        pending_q.push_back(rec);
        req.rd   = 1'b1;
        req.addr = cells[1];
        req.size = sdram_pkg::size_32;
        wait_ack(1'b1, n);
        t1 = cycle_cnt;
        wait_ack(1'b0, n);
        check_word(32'(n), 32'd7, "ack high cycles, first held read");
        wait_ack(1'b1, n);
        t2 = cycle_cnt;
        req.rd = 1'b0;
        wait_ack(1'b0, n);
        check_word(32'(t2 - t1), 32'd9, "cycles between back-to-back acks");

        if (pending_q.size() != 0 || model_fault || dut.u_props.fail_count != 0)
            fail_run("run ended with unchecked reads, a model fault or a failed assertion");
        else
        begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

// File: sources.f
+incdir+source
source/sdram_pkg.sv
source/sdram_sequencer.sv
source/sdram_lane_map.sv
source/sdram_pin_stage.sv
source/sdram_ctrl.sv
dv/sdram_model.sv
dv/sdram_properties.sv
dv/tb_sdram_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the SDRAM controller testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_sdram_ctrl -f sources.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx '\*\* PASS \*\*' "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
